// File: Makefile
# Verilator flow for the HDC core testbench.
# Any variable can be set on the command line, e.g. make sim SEED=12345

VERILATOR ?= verilator
TOP       ?= tb_hdc_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

# 1404425484 is 0x53b5d50c
SEED      ?= 1404425484

LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# the run result is judged only by the log contents
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
		echo "sim: PASS"; \
	else \
		echo "sim: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdc_consts.svh
`ifndef HDC_CONSTS_SVH
`define HDC_CONSTS_SVH

// hypervector width, one word per vector
`define HDC_VEC_W 64

// hardware thread lanes
`define HDC_THREADS 5

// item memory size and its address width
`define HDC_ITEM_DEPTH 512
`define HDC_ADDR_W 9

// raw instruction word width
`define HDC_INST_W 16

`endif

// File: project.f
+incdir+.
verilog/hdc_vec_pkg.sv
verilog/hdc_isa_pkg.sv
verilog/inst_decoder.sv
verilog/item_memory.sv
verilog/thread_lane.sv
verilog/result_unit.sv
verilog/hdc_core.sv
tb/tb_hdc_core.sv

// File: tb/tb_hdc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module tb_hdc_core #(
    parameter int unsigned SEED = 32'h53b5_d50c
);

    // all directed tests together stay well under 1000 cycles
    localparam int MAX_CYCLES = 3000;
    localparam int NT = `HDC_THREADS;

    logic                    clk;
    logic                    reset;
    logic                    run;
    logic                    exec;
    logic                    get_v;
    hdc_isa_pkg::inst_word_t get_d;
    logic                    gen;
    logic                    update_item;
    hdc_vec_pkg::item_addr_t item_a;
    hdc_vec_pkg::hv_t        rand_num;
    hdc_vec_pkg::hv_t        sign_bit;
    logic                    store;
    hdc_vec_pkg::hv_t        core_result;
    logic                    last;

    // reference model of item memory and lanes
    hdc_vec_pkg::hv_t model_mem [0:`HDC_ITEM_DEPTH-1];
    hdc_vec_pkg::hv_t model_acc [NT];
    hdc_vec_pkg::hv_t model_opnd [NT];
    logic             model_last;

    // program being built, one op and one address per word
    hdc_isa_pkg::opcode_e    prog_op [$];
    hdc_vec_pkg::item_addr_t prog_addr [$];

    int cycles = 0;

    hdc_core i_dut (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .exec        (exec),
        .get_v       (get_v),
        .get_d       (get_d),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .rand_num    (rand_num),
        .sign_bit    (sign_bit),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            report_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vec(input string name, input hdc_vec_pkg::hv_t got,
                             input hdc_vec_pkg::hv_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
        end
    endtask

    // word encoding as the ISA defines it, address in bits 8:0
    function automatic hdc_isa_pkg::inst_word_t encode_word(input hdc_isa_pkg::opcode_e op,
                                                            input hdc_vec_pkg::item_addr_t a);
        hdc_isa_pkg::inst_word_t w;
        w = '0;
        case (op)
            hdc_isa_pkg::op_load:    w = {7'b1010000, a};
            hdc_isa_pkg::op_wb_item: w = {7'b1001000, a};
            hdc_isa_pkg::op_xor:     w = 16'h2000;
            hdc_isa_pkg::op_store:   w = 16'h1000;
            hdc_isa_pkg::op_move:    w = 16'h0800;
            hdc_isa_pkg::op_last:    w = 16'h0400;
            hdc_isa_pkg::op_sign:    w = 16'h0200;
            default:                 w = '0;
        endcase
        return w;
    endfunction

    function automatic hdc_vec_pkg::hv_t rand_vec();
        return {$urandom(), $urandom()};
    endfunction

    task automatic add_word(input hdc_isa_pkg::opcode_e op, input hdc_vec_pkg::item_addr_t a);
        prog_op.push_back(op);
        prog_addr.push_back(a);
    endtask

    task automatic add_nops(input int n);
        for (int i = 0; i < n; i++) begin
            add_word(hdc_isa_pkg::op_nop, '0);
        end
    endtask

    task automatic gen_item(input hdc_vec_pkg::item_addr_t a, input hdc_vec_pkg::hv_t v);
        @(negedge clk);
        gen         = 1'b1;
        update_item = 1'b1;
        item_a      = a;
        rand_num    = v;
        @(negedge clk);
        gen         = 1'b0;
        update_item = 1'b0;
        model_mem[a] = v;
    endtask

    // drives the burst and checks store, core_result and last every cycle;
    // word j shows up on the outputs two negedges after it was driven
    task automatic run_program();
        int                   n;
        int                   j;
        int                   t;
        hdc_isa_pkg::opcode_e wop;
        logic                 exp_store;
        hdc_vec_pkg::hv_t     exp_res;
        n = prog_op.size();
        for (int i = 0; i < n + 2; i++) begin
            @(negedge clk);
            exp_store = 1'b0;
            exp_res   = '0;
            if (i >= 2) begin
                j   = i - 2;
                t   = j % NT;
                wop = prog_op[j];
                case (wop)
                    hdc_isa_pkg::op_load:    model_acc[t] = model_mem[prog_addr[j]];
                    hdc_isa_pkg::op_xor:     model_acc[t] = model_acc[t] ^ model_opnd[t];
                    hdc_isa_pkg::op_move:    model_opnd[t] = model_acc[t];
                    hdc_isa_pkg::op_sign:    model_acc[t] = sign_bit;
                    hdc_isa_pkg::op_last:    model_last = 1'b1;
                    hdc_isa_pkg::op_wb_item: model_mem[prog_addr[j]] = model_acc[t];
                    hdc_isa_pkg::op_store: begin
                        exp_store = 1'b1;
                        exp_res   = model_acc[t];
                    end
                    default: begin
                    end
                endcase
            end
            check_bit("store", store, exp_store);
            check_vec("core_result", core_result, exp_res);
            check_bit("last", last, model_last);
            if (i < n) begin
                get_v = 1'b1;
                get_d = encode_word(prog_op[i], prog_addr[i]);
            end else begin
                get_v = 1'b0;
                get_d = '0;
            end
        end
        prog_op.delete();
        prog_addr.delete();
    endtask

    task automatic test_after_reset();
        @(negedge clk);
        check_bit("store", store, 1'b0);
        check_bit("last", last, 1'b0);
        check_vec("core_result", core_result, '0);
    endtask

    task automatic test_gen_load_store();
        gen_item(9'd3, rand_vec());
        gen_item(9'd17, rand_vec());
        gen_item(9'd200, rand_vec());
        gen_item(9'd511, rand_vec());
        add_word(hdc_isa_pkg::op_load, 9'd17);
        add_nops(4);
        add_word(hdc_isa_pkg::op_store, '0);
        run_program();
    endtask

    // thread 0 binds two items, thread 1 holds a third for the back-to-back store
    task automatic test_xor_chain();
        add_word(hdc_isa_pkg::op_load, 9'd3);
        add_word(hdc_isa_pkg::op_load, 9'd511);
        add_nops(3);
        add_word(hdc_isa_pkg::op_move, '0);
        add_nops(4);
        add_word(hdc_isa_pkg::op_load, 9'd200);
        add_nops(4);
        add_word(hdc_isa_pkg::op_xor, '0);
        add_nops(4);
        add_word(hdc_isa_pkg::op_store, '0);
        add_word(hdc_isa_pkg::op_store, '0);
        run_program();
    endtask

    task automatic test_sign_load();
        @(negedge clk);
        sign_bit = rand_vec();
        add_word(hdc_isa_pkg::op_sign, '0);
        add_nops(4);
        add_word(hdc_isa_pkg::op_store, '0);
        run_program();
    endtask

    task automatic test_write_back();
        add_word(hdc_isa_pkg::op_load, 9'd17);
        add_nops(4);
        add_word(hdc_isa_pkg::op_wb_item, 9'd100);
        run_program();
        // read the new item back through thread 1
        add_word(hdc_isa_pkg::op_nop, '0);
        add_word(hdc_isa_pkg::op_load, 9'd100);
        add_nops(4);
        add_word(hdc_isa_pkg::op_store, '0);
        run_program();
    endtask

    task automatic test_last_and_run();
        add_word(hdc_isa_pkg::op_load, 9'd3);
        add_word(hdc_isa_pkg::op_last, '0);
        run_program();
        repeat (5) begin
            @(negedge clk);
            check_bit("last", last, 1'b1);
        end
        run = 1'b0;
        @(negedge clk);
        for (int t = 0; t < NT; t++) begin
            model_acc[t]  = '0;
            model_opnd[t] = '0;
        end
        model_last = 1'b0;
        check_bit("last", last, 1'b0);
        check_bit("store", store, 1'b0);
        run = 1'b1;
        // thread 0 had an item before run dropped, now it must read back zero
        add_word(hdc_isa_pkg::op_store, '0);
        run_program();
    endtask

    initial begin
        void'($urandom(SEED));
        reset       = 1'b1;
        run         = 1'b1;
        exec        = 1'b1;
        get_v       = 1'b0;
        get_d       = '0;
        gen         = 1'b0;
        update_item = 1'b0;
        item_a      = '0;
        rand_num    = '0;
        sign_bit    = '0;
        for (int a = 0; a < `HDC_ITEM_DEPTH; a++) begin
            model_mem[a] = '0;
        end
        for (int t = 0; t < NT; t++) begin
            model_acc[t]  = '0;
            model_opnd[t] = '0;
        end
        model_last = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_after_reset();
        test_gen_load_store();
        test_xor_chain();
        test_sign_load();
        test_write_back();
        test_last_and_run();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/hdc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_core (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    run,
    input  wire logic                    exec,
    input  wire logic                    get_v,
    input  wire hdc_isa_pkg::inst_word_t get_d,
    input  wire logic                    gen,
    input  wire logic                    update_item,
    input  wire hdc_vec_pkg::item_addr_t item_a,
    input  wire hdc_vec_pkg::hv_t        rand_num,
    input  wire hdc_vec_pkg::hv_t        sign_bit,
    output logic                         store,
    output hdc_vec_pkg::hv_t             core_result,
    output logic                         last
);

    // decoded word, one cycle after get_v
    hdc_isa_pkg::opcode_e    op;
    hdc_vec_pkg::thread_t    thread;
    logic                    wb_en;
    hdc_vec_pkg::item_addr_t wb_addr;

    // item read lines up with op
    hdc_vec_pkg::hv_t rd_data;
    hdc_vec_pkg::hv_t wb_data;
    hdc_vec_pkg::hv_t lane_acc [`HDC_THREADS];

    inst_decoder u_decoder (
        .clk     (clk),
        .reset   (reset),
        .get_v   (get_v),
        .get_d   (get_d),
        .op      (op),
        .thread  (thread),
        .wb_en   (wb_en),
        .wb_addr (wb_addr)
    );

    item_memory u_item_memory (
        .clk         (clk),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .rand_num    (rand_num),
        .rd_addr     (get_d[`HDC_ADDR_W-1:0]),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .rd_data     (rd_data)
    );

    // one lane per hardware thread
    for (genvar i = 0; i < `HDC_THREADS; i++) begin : g_lane
        thread_lane #(
            .LANE_ID (i)
        ) u_lane (
            .clk       (clk),
            .reset     (reset),
            .run       (run),
            .exec      (exec),
            .op        (op),
            .thread    (thread),
            .load_data (rd_data),
            .sign_bit  (sign_bit),
            .acc       (lane_acc[i])
        );
    end

    result_unit u_result (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .exec        (exec),
        .op          (op),
        .thread      (thread),
        .lane_acc    (lane_acc),
        .wb_data     (wb_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

endmodule

`default_nettype wire

// File: verilog/hdc_isa_pkg.sv
`include "hdc_consts.svh"

package hdc_isa_pkg;

    // raw word as it arrives on get_d, address in the low bits
    typedef logic [`HDC_INST_W-1:0] inst_word_t;

    // decoded operation
    typedef enum logic [2:0] {
        op_nop,
        op_load,
        op_wb_item,
        op_xor,
        op_store,
        op_move,
        op_last,
        op_sign
    } opcode_e;

    // bit 15 marks words that carry an address
    function automatic opcode_e decode_op(inst_word_t w);
        opcode_e op;
        if (w[15] && w[12]) begin
            op = op_wb_item;
        end else if (w[15] && w[13]) begin
            op = op_load;
        end else if (w[15]) begin
            op = op_nop;
        end else if (w[13]) begin
            op = op_xor;
        end else if (w[12]) begin
            op = op_store;
        end else if (w[11]) begin
            op = op_move;
        end else if (w[10]) begin
            op = op_last;
        end else if (w[9]) begin
            op = op_sign;
        end else begin
            op = op_nop;
        end
        return op;
    endfunction

endpackage

// File: verilog/hdc_vec_pkg.sv
`include "hdc_consts.svh"

package hdc_vec_pkg;

    // one hypervector
    typedef logic [`HDC_VEC_W-1:0] hv_t;

    // item memory address
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // thread index, wide enough for all lanes
    typedef logic [$clog2(`HDC_THREADS)-1:0] thread_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module inst_decoder (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    get_v,
    input  wire hdc_isa_pkg::inst_word_t get_d,
    output hdc_isa_pkg::opcode_e         op,
    output hdc_vec_pkg::thread_t         thread,
    output logic                         wb_en,
    output hdc_vec_pkg::item_addr_t      wb_addr
);

    localparam hdc_vec_pkg::thread_t LAST_THREAD = hdc_vec_pkg::thread_t'(`HDC_THREADS - 1);

    hdc_isa_pkg::opcode_e dec_op;

    assign dec_op = hdc_isa_pkg::decode_op(get_d);

    always_ff @(posedge clk) begin
        if (reset || !get_v) begin
            // idle: park on the last thread so the next burst starts at 0
            op      <= hdc_isa_pkg::op_nop;
            thread  <= LAST_THREAD;
            wb_en   <= 1'b0;
            wb_addr <= '0;
        end else begin
            if (dec_op == hdc_isa_pkg::op_wb_item) begin
                // write-back goes to the item memory, lanes see a nop
                op      <= hdc_isa_pkg::op_nop;
                wb_en   <= 1'b1;
                wb_addr <= get_d[`HDC_ADDR_W-1:0];
            end else begin
                op      <= dec_op;
                wb_en   <= 1'b0;
                wb_addr <= '0;
            end

            // round robin over the lanes, one word each
            if (thread == LAST_THREAD) begin
                thread <= '0;
            end else begin
                thread <= thread + 1'b1;
            end
        end
    end

    thread_in_range: assert property (
        @(posedge clk) disable iff (reset)
        thread <= LAST_THREAD
    ) else $error("thread index out of range");

    // a write-back word must not also start a lane operation
    wb_is_nop: assert property (
        @(posedge clk) disable iff (reset)
        wb_en |-> op == hdc_isa_pkg::op_nop
    ) else $error("write-back issued with a lane op");

endmodule

`default_nettype wire

// File: verilog/item_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module item_memory (
    input  wire logic                    clk,
    input  wire logic                    gen,
    input  wire logic                    update_item,
    input  wire hdc_vec_pkg::item_addr_t item_a,
    input  wire hdc_vec_pkg::hv_t        rand_num,
    input  wire hdc_vec_pkg::item_addr_t rd_addr,
    input  wire logic                    wb_en,
    input  wire hdc_vec_pkg::item_addr_t wb_addr,
    input  wire hdc_vec_pkg::hv_t        wb_data,
    output hdc_vec_pkg::hv_t             rd_data
);

    // block RAM, one write port and one read port
    hdc_vec_pkg::hv_t mem [0:`HDC_ITEM_DEPTH-1];

    logic gen_we;

    assign gen_we = gen && update_item;

    always_ff @(posedge clk) begin
        // write-back wins over random item generation
        if (wb_en) begin
            mem[wb_addr] <= wb_data;
        end else if (gen_we) begin
            mem[item_a] <= rand_num;
        end

        // read every cycle, used only on load
        rd_data <= mem[rd_addr];
    end

    // a dropped generate write must not hit the write-back address
    no_write_clash: assert property (
        @(posedge clk)
        !(wb_en && gen_we && wb_addr == item_a)
    ) else $error("generate and write-back target the same item");

endmodule

`default_nettype wire

// File: verilog/result_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module result_unit (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 run,
    input  wire logic                 exec,
    input  wire hdc_isa_pkg::opcode_e op,
    input  wire hdc_vec_pkg::thread_t thread,
    input  wire hdc_vec_pkg::hv_t     lane_acc [`HDC_THREADS],
    output hdc_vec_pkg::hv_t          wb_data,
    output logic                      store,
    output hdc_vec_pkg::hv_t          core_result,
    output logic                      last
);

    hdc_vec_pkg::hv_t sel_acc;
    hdc_vec_pkg::hv_t buff;
    logic do_store;

    // accumulator of the thread in the current slot
    always_comb begin
        sel_acc = '0;
        for (int i = 0; i < `HDC_THREADS; i++) begin
            if (thread == hdc_vec_pkg::thread_t'(i)) begin
                sel_acc = lane_acc[i];
            end
        end
    end

    assign wb_data  = sel_acc;
    assign do_store = run && exec && (op == hdc_isa_pkg::op_store);

    always_ff @(posedge clk) begin
        if (reset || !run || !exec) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            // one pulse per store word
            store <= (op == hdc_isa_pkg::op_store);
            // last holds until exec or run drops
            if (op == hdc_isa_pkg::op_last) begin
                last <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_store) begin
            buff <= sel_acc;
        end
    end

    // result bus is quiet outside the pulse
    assign core_result = store ? buff : '0;

    store_pulse_only: assert property (
        @(posedge clk) disable iff (reset)
        store && $past(store) |->
            $past(op, 1) == hdc_isa_pkg::op_store && $past(op, 2) == hdc_isa_pkg::op_store
    ) else $error("store held without back-to-back store ops");

endmodule

`default_nettype wire

// File: verilog/thread_lane.sv
`timescale 1ns/1ps
`default_nettype none

module thread_lane #(
    parameter int LANE_ID = 0
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 run,
    input  wire logic                 exec,
    input  wire hdc_isa_pkg::opcode_e op,
    input  wire hdc_vec_pkg::thread_t thread,
    input  wire hdc_vec_pkg::hv_t     load_data,
    input  wire hdc_vec_pkg::hv_t     sign_bit,
    output hdc_vec_pkg::hv_t          acc
);

    localparam hdc_vec_pkg::thread_t MY_ID = hdc_vec_pkg::thread_t'(LANE_ID);

    // operand register, filled by move
    hdc_vec_pkg::hv_t operand;
    logic active;

    // this lane owns the current slot
    assign active = run && exec && (thread == MY_ID);

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            operand <= '0;
            acc     <= '0;
        end else if (active) begin
            case (op)
                hdc_isa_pkg::op_load: begin
                    acc <= load_data;
                end
                hdc_isa_pkg::op_xor: begin
                    // binding of two hypervectors
                    acc <= operand ^ acc;
                end
                hdc_isa_pkg::op_move: begin
                    operand <= acc;
                end
                hdc_isa_pkg::op_sign: begin
                    acc <= sign_bit;
                end
                default: begin
                    // store, last and nop leave the registers alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire
